// ==== hdl/cpuSettings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path, address and instruction width
`define CPU_WORD_WIDTH 16

// Architectural registers, R0 reads as zero
`define CPU_REG_COUNT 16

// JAL return address goes here
`define CPU_LINK_REG 15

// First fetch address out of reset
`define CPU_RESET_PC 0

`endif

// ==== hdl/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Major opcode in instr[15:12]
  typedef enum logic [3:0] {
    opAdd  = 4'b0000,
    opAddz = 4'b0001,
    opSub  = 4'b0010,
    opAnd  = 4'b0011,
    opNor  = 4'b0100,
    opSll  = 4'b0101,
    opSrl  = 4'b0110,
    opSra  = 4'b0111,
    opLw   = 4'b1000,
    opSw   = 4'b1001,
    opLhb  = 4'b1010,
    opLlb  = 4'b1011,
    opB    = 4'b1100,
    opJal  = 4'b1101,
    opJr   = 4'b1110,
    opHlt  = 4'b1111
  } opcodeT;

  // Matches instr[14:12] for register ops
  // Slot 001 is free since ADDZ runs as add, so the byte merge lives there
  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluLhb = 3'b001,
    aluSub = 3'b010,
    aluAnd = 3'b011,
    aluNor = 3'b100,
    aluSll = 3'b101,
    aluSrl = 3'b110,
    aluSra = 3'b111
  } aluOpT;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    condNe     = 3'b000,
    condEq     = 3'b001,
    condGt     = 3'b010,
    condLt     = 3'b011,
    condGe     = 3'b100,
    condLe     = 3'b101,
    condOv     = 3'b110,
    condAlways = 3'b111
  } branchCondT;

endpackage

`default_nettype wire

// ==== hdl/ctrlPkg.sv ====
`default_nettype none

`include "cpuSettings.svh"

package ctrlPkg;

  // Condition flags held between instructions
  typedef struct packed {
    logic zero;
    logic overflow;
    logic negative;
  } flagsT;

  // Decoded control for one instruction
  typedef struct packed {
    isaPkg::aluOpT      aluOp;
    isaPkg::branchCondT branchCond;
    logic               regWe;
    logic               memRe;
    logic               memWe;
    logic               memToReg;
    logic               isBranch;
    logic               isJal;
    logic               isJr;
    logic               isHalt;
    // Second ALU operand from the instruction word
    logic               immSel;
    // Write only if zero flag set (ADDZ)
    logic               condWrite;
    logic               ovEn;
    logic               zrEn;
    logic               neEn;
  } ctrlT;

  // Data memory request, strobes are plain single-cycle levels
  typedef struct packed {
    logic [`CPU_WORD_WIDTH-1:0] addr;
    logic [`CPU_WORD_WIDTH-1:0] wdata;
    logic                       we;
    logic                       re;
  } memReqT;

endpackage

`default_nettype wire

// ==== hdl/instrDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpuSettings.svh"

module instrDecode (
  input  wire logic [`CPU_WORD_WIDTH-1:0] instr,
  output ctrlPkg::ctrlT                   ctrl,
  output logic [3:0]                      srcAddr0,
  output logic [3:0]                      srcAddr1,
  output logic [3:0]                      dstAddr
);

  isaPkg::opcodeT opcode;

  assign opcode = isaPkg::opcodeT'(instr[15:12]);

  always_comb begin
    ctrl = '0;
    // Address math for memory ops and LLB rides on add
    ctrl.aluOp = isaPkg::aluAdd;
    ctrl.branchCond = isaPkg::branchCondT'(instr[11:9]);
    // Whole lower half of the opcode map touches Z
    ctrl.zrEn = ~instr[15];
    case (opcode)
      isaPkg::opAdd, isaPkg::opSub: begin
        ctrl.aluOp = isaPkg::aluOpT'(instr[14:12]);
        ctrl.regWe = 1'b1;
        ctrl.ovEn = 1'b1;
        ctrl.neEn = 1'b1;
      end
      isaPkg::opAddz: begin
        ctrl.regWe = 1'b1;
        ctrl.condWrite = 1'b1;
        ctrl.ovEn = 1'b1;
        ctrl.neEn = 1'b1;
      end
      isaPkg::opAnd, isaPkg::opNor, isaPkg::opSll, isaPkg::opSrl, isaPkg::opSra: begin
        ctrl.aluOp = isaPkg::aluOpT'(instr[14:12]);
        ctrl.regWe = 1'b1;
      end
      isaPkg::opLw: begin
        ctrl.memRe = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWe = 1'b1;
        ctrl.immSel = 1'b1;
      end
      isaPkg::opSw: begin
        ctrl.memWe = 1'b1;
        ctrl.immSel = 1'b1;
      end
      isaPkg::opLhb: begin
        ctrl.aluOp = isaPkg::aluLhb;
        ctrl.regWe = 1'b1;
        ctrl.immSel = 1'b1;
      end
      isaPkg::opLlb: begin
        ctrl.regWe = 1'b1;
        ctrl.immSel = 1'b1;
      end
      isaPkg::opB: ctrl.isBranch = 1'b1;
      isaPkg::opJal: begin
        ctrl.isJal = 1'b1;
        ctrl.regWe = 1'b1;
      end
      isaPkg::opJr: ctrl.isJr = 1'b1;
      default: ctrl.isHalt = 1'b1;
    endcase
  end

  // LHB merges into rd so rd is read on port 0
  // LLB adds its immediate to R0
  assign srcAddr0 = (opcode == isaPkg::opLhb) ? instr[11:8] :
                    (opcode == isaPkg::opLlb) ? 4'd0 :
                    instr[7:4];

  // Store data register comes out on port 1
  assign srcAddr1 = (opcode == isaPkg::opSw) ? instr[11:8] : instr[3:0];

  assign dstAddr = ctrl.isJal ? 4'(`CPU_LINK_REG) : instr[11:8];

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpuSettings.svh"

module regFile (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire logic [3:0]                 rdAddr0,
  input  wire logic [3:0]                 rdAddr1,
  input  wire logic [3:0]                 wrAddr,
  input  wire logic                       wrEn,
  input  wire logic [`CPU_WORD_WIDTH-1:0] wrData,
  output logic [`CPU_WORD_WIDTH-1:0]      rdData0,
  output logic [`CPU_WORD_WIDTH-1:0]      rdData1
);

  logic [`CPU_WORD_WIDTH-1:0] regs [`CPU_REG_COUNT];

  // Writes to R0 are dropped
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != 4'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read ports are combinational, no bypass from the write port
  assign rdData0 = (rdAddr0 == 4'd0) ? '0 : regs[rdAddr0];
  assign rdData1 = (rdAddr1 == 4'd0) ? '0 : regs[rdAddr1];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpuSettings.svh"

module alu (
  input  wire ctrlPkg::ctrlT              ctrl,
  input  wire logic [`CPU_WORD_WIDTH-1:0] opA,
  input  wire logic [`CPU_WORD_WIDTH-1:0] opB,
  input  wire logic [`CPU_WORD_WIDTH-1:0] instr,
  output logic [`CPU_WORD_WIDTH-1:0]      result,
  output ctrlPkg::flagsT                  flagsNext
);

  logic [`CPU_WORD_WIDTH-1:0] immMem;
  logic [`CPU_WORD_WIDTH-1:0] immByte;
  logic [`CPU_WORD_WIDTH-1:0] opBSel;
  logic [`CPU_WORD_WIDTH-1:0] sum;
  logic [`CPU_WORD_WIDTH-1:0] diff;
  logic [3:0]                 shamt;
  logic                       overflow;

  // Signed 4-bit offset for LW and SW
  assign immMem = {{(`CPU_WORD_WIDTH-4){instr[3]}}, instr[3:0]};
  // Byte immediate for LLB and LHB
  assign immByte = {{(`CPU_WORD_WIDTH-8){instr[7]}}, instr[7:0]};
  // Shifts take rt field as amount
  assign shamt = instr[3:0];

  assign opBSel = !ctrl.immSel ? opB :
                  (ctrl.memRe | ctrl.memWe) ? immMem :
                  immByte;

  assign sum = opA + opBSel;
  assign diff = opA - opBSel;

  always_comb begin
    result = sum;
    overflow = 1'b0;
    case (ctrl.aluOp)
      isaPkg::aluAdd: begin
        // Same-sign inputs giving a flipped sign
        overflow = (opA[15] == opBSel[15]) && (sum[15] != opA[15]);
      end
      isaPkg::aluSub: begin
        result = diff;
        overflow = (opA[15] != opBSel[15]) && (diff[15] != opA[15]);
      end
      isaPkg::aluAnd: result = opA & opBSel;
      isaPkg::aluNor: result = ~(opA | opBSel);
      isaPkg::aluSll: result = opA << shamt;
      isaPkg::aluSrl: result = opA >> shamt;
      isaPkg::aluSra: result = $signed(opA) >>> shamt;
      // New high byte, old low byte of rd
      default: result = {immByte[7:0], opA[7:0]};
    endcase
  end

  assign flagsNext.zero = (result == '0);
  assign flagsNext.overflow = overflow;
  assign flagsNext.negative = result[`CPU_WORD_WIDTH-1];

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpuSettings.svh"

module fetchUnit (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire ctrlPkg::ctrlT              ctrl,
  input  wire logic [`CPU_WORD_WIDTH-1:0] instr,
  input  wire ctrlPkg::flagsT             flagsNext,
  input  wire logic [`CPU_WORD_WIDTH-1:0] jumpReg,
  output logic [`CPU_WORD_WIDTH-1:0]      pc,
  output logic [`CPU_WORD_WIDTH-1:0]      linkPc,
  output ctrlPkg::flagsT                  flags,
  output logic                            halted
);

  logic [`CPU_WORD_WIDTH-1:0] branchOff;
  logic [`CPU_WORD_WIDTH-1:0] jalOff;
  logic [`CPU_WORD_WIDTH-1:0] pcNext;
  logic                       taken;

  assign linkPc = pc + 1'b1;
  assign branchOff = {{(`CPU_WORD_WIDTH-9){instr[8]}}, instr[8:0]};
  assign jalOff = {{(`CPU_WORD_WIDTH-12){instr[11]}}, instr[11:0]};

  // Condition tested against flags left by earlier instructions
  always_comb begin
    taken = 1'b0;
    case (ctrl.branchCond)
      isaPkg::condNe: taken = !flags.zero;
      isaPkg::condEq: taken = flags.zero;
      isaPkg::condGt: taken = !flags.zero && !flags.negative;
      isaPkg::condLt: taken = flags.negative;
      isaPkg::condGe: taken = flags.zero || !flags.negative;
      isaPkg::condLe: taken = flags.zero || flags.negative;
      isaPkg::condOv: taken = flags.overflow;
      default: taken = 1'b1;
    endcase
  end

  // Relative targets count from PC+1, no delay slot
  always_comb begin
    pcNext = linkPc;
    if (ctrl.isHalt) begin
      pcNext = pc;
    end else if (ctrl.isJr) begin
      pcNext = jumpReg;
    end else if (ctrl.isJal) begin
      pcNext = linkPc + jalOff;
    end else if (ctrl.isBranch && taken) begin
      pcNext = linkPc + branchOff;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= `CPU_WORD_WIDTH'(`CPU_RESET_PC);
    end else if (!halted) begin
      pc <= pcNext;
    end
  end

  // Each flag only moves under its own enable
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (!halted) begin
      if (ctrl.zrEn) begin
        flags.zero <= flagsNext.zero;
      end
      if (ctrl.ovEn) begin
        flags.overflow <= flagsNext.overflow;
      end
      if (ctrl.neEn) begin
        flags.negative <= flagsNext.negative;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (ctrl.isHalt) begin
      halted <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpuCore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpuSettings.svh"

module cpuCore (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  output logic [`CPU_WORD_WIDTH-1:0]      imemAddr,
  input  wire logic [`CPU_WORD_WIDTH-1:0] imemData,
  output ctrlPkg::memReqT                 dmemReq,
  input  wire logic [`CPU_WORD_WIDTH-1:0] dmemRdata,
  output logic                            halted
);

  ctrlPkg::ctrlT              ctrl;
  ctrlPkg::flagsT             flags;
  ctrlPkg::flagsT             flagsNext;
  logic [3:0]                 srcAddr0;
  logic [3:0]                 srcAddr1;
  logic [3:0]                 dstAddr;
  logic [`CPU_WORD_WIDTH-1:0] rdData0;
  logic [`CPU_WORD_WIDTH-1:0] rdData1;
  logic [`CPU_WORD_WIDTH-1:0] aluResult;
  logic [`CPU_WORD_WIDTH-1:0] wbData;
  logic [`CPU_WORD_WIDTH-1:0] pc;
  logic [`CPU_WORD_WIDTH-1:0] linkPc;
  logic                       regWr;

  instrDecode instrDecode_inst (
    .instr    (imemData),
    .ctrl     (ctrl),
    .srcAddr0 (srcAddr0),
    .srcAddr1 (srcAddr1),
    .dstAddr  (dstAddr)
  );

  regFile regFile_inst (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddr0 (srcAddr0),
    .rdAddr1 (srcAddr1),
    .wrAddr  (dstAddr),
    .wrEn    (regWr),
    .wrData  (wbData),
    .rdData0 (rdData0),
    .rdData1 (rdData1)
  );

  alu alu_inst (
    .ctrl      (ctrl),
    .opA       (rdData0),
    .opB       (rdData1),
    .instr     (imemData),
    .result    (aluResult),
    .flagsNext (flagsNext)
  );

  // Port 0 also carries the JR target
  fetchUnit fetchUnit_inst (
    .clk       (clk),
    .rstN      (rstN),
    .ctrl      (ctrl),
    .instr     (imemData),
    .flagsNext (flagsNext),
    .jumpReg   (rdData0),
    .pc        (pc),
    .linkPc    (linkPc),
    .flags     (flags),
    .halted    (halted)
  );

  assign imemAddr = pc;

  // ALU sum is the effective address, port 1 holds store data
  assign dmemReq.addr = aluResult;
  assign dmemReq.wdata = rdData1;
  assign dmemReq.we = ctrl.memWe & ~halted;
  assign dmemReq.re = ctrl.memRe & ~halted;

  // Link value for JAL, load data for LW, otherwise ALU
  assign wbData = ctrl.isJal ? linkPc :
                  ctrl.memToReg ? dmemRdata :
                  aluResult;

  // ADDZ looks at Z as it stood before this instruction
  assign regWr = ctrl.regWe & ~halted & (~ctrl.condWrite | flags.zero);

endmodule

`default_nettype wire

// ==== testbench/cpuCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpuSettings.svh"

module cpuCoreTb;

  localparam int PeriodNs = 10;
  localparam int ResetCycles = 16;
  localparam int MarginCycles = 32;
  localparam int RomDepth = 128;
  localparam int RamDepth = 256;

  // One row per ROM address, in address order
  typedef struct packed {
    logic [`CPU_WORD_WIDTH-1:0] instr;
    logic [`CPU_WORD_WIDTH-1:0] nextAddr;
    logic                       store;
    logic [`CPU_WORD_WIDTH-1:0] addr;
    logic [`CPU_WORD_WIDTH-1:0] data;
  } stepT;

  logic                       clk;
  logic                       rstN;
  logic [`CPU_WORD_WIDTH-1:0] imemAddr;
  logic [`CPU_WORD_WIDTH-1:0] imemData;
  ctrlPkg::memReqT            dmemReq;
  logic [`CPU_WORD_WIDTH-1:0] dmemRdata;
  logic                       halted;

  logic [`CPU_WORD_WIDTH-1:0] rom [RomDepth];
  logic [`CPU_WORD_WIDTH-1:0] ram [RamDepth];
  stepT                       steps [$];

  cpuCore cpuCore_inst (
    .clk       (clk),
    .rstN      (rstN),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // Instruction word follows the PC and changes on the falling edge
  always @(negedge clk) begin
    imemData <= rom[imemAddr[6:0]];
  end

  // Data RAM with a combinational read port and a write on the rising edge
  assign dmemRdata = ram[dmemReq.addr[7:0]];

  always @(posedge clk) begin
    if (dmemReq.we) begin
      ram[dmemReq.addr[7:0]] <= dmemReq.wdata;
    end
  end

  task automatic compareValue(input string name, input logic [`CPU_WORD_WIDTH-1:0] actual,
                              input logic [`CPU_WORD_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("error %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic addStep(input logic [15:0] instr, input logic [15:0] nextAddr,
                         input logic store, input logic [15:0] addr, input logic [15:0] data);
    stepT s;
    s.instr = instr;
    s.nextAddr = nextAddr;
    s.store = store;
    s.addr = addr;
    s.data = data;
    steps.push_back(s);
  endtask

  // Instruction, next fetch address, store flag, store address, store data
  // Skipped slots hold HLT pointing at themselves
  task automatic loadProgram();
    // Constants from LLB and LHB
    addStep(16'hB140, 1, 0, 0, 0);
    addStep(16'hB285, 2, 0, 0, 0);
    addStep(16'hA212, 3, 0, 0, 0);
    addStep(16'h9210, 4, 1, 16'h0040, 16'h1285);
    addStep(16'hB37F, 5, 0, 0, 0);
    addStep(16'hA37F, 6, 0, 0, 0);
    // ALU results, each stored at base plus signed offset
    addStep(16'h0433, 7, 0, 0, 0);
    addStep(16'h9411, 8, 1, 16'h0041, 16'hFEFE);
    addStep(16'h2523, 9, 0, 0, 0);
    addStep(16'h951F, 10, 1, 16'h003F, 16'h9306);
    addStep(16'h3623, 11, 0, 0, 0);
    addStep(16'h9612, 12, 1, 16'h0042, 16'h1205);
    addStep(16'h4724, 13, 0, 0, 0);
    addStep(16'h9713, 14, 1, 16'h0043, 16'h0100);
    addStep(16'h5824, 15, 0, 0, 0);
    addStep(16'h9814, 16, 1, 16'h0044, 16'h2850);
    addStep(16'h6943, 17, 0, 0, 0);
    addStep(16'h9915, 18, 1, 16'h0045, 16'h1FDF);
    addStep(16'h7A43, 19, 0, 0, 0);
    addStep(16'h9A16, 20, 1, 16'h0046, 16'hFFDF);
    // Loads of preloaded words, then stored back
    addStep(16'hBB50, 21, 0, 0, 0);
    addStep(16'h8CB0, 22, 0, 0, 0);
    addStep(16'h8DBE, 23, 0, 0, 0);
    addStep(16'h9C17, 24, 1, 16'h0047, 16'hBEEF);
    addStep(16'h9DB1, 25, 1, 16'h0051, 16'h1357);
    // Z set
    addStep(16'h2E22, 26, 0, 0, 0);
    addStep(16'hC001, 27, 0, 0, 0);
    addStep(16'hC201, 29, 0, 0, 0);
    addStep(16'hF000, 28, 0, 0, 0);
    addStep(16'hC401, 30, 0, 0, 0);
    addStep(16'hC801, 32, 0, 0, 0);
    addStep(16'hF000, 31, 0, 0, 0);
    // Positive nonzero result
    addStep(16'h0E20, 33, 0, 0, 0);
    addStep(16'hC001, 35, 0, 0, 0);
    addStep(16'hF000, 34, 0, 0, 0);
    addStep(16'hC201, 36, 0, 0, 0);
    addStep(16'hC401, 38, 0, 0, 0);
    addStep(16'hF000, 37, 0, 0, 0);
    addStep(16'hC601, 39, 0, 0, 0);
    addStep(16'hCA01, 40, 0, 0, 0);
    addStep(16'hCC01, 41, 0, 0, 0);
    // Negative result
    addStep(16'h2E02, 42, 0, 0, 0);
    addStep(16'hC601, 44, 0, 0, 0);
    addStep(16'hF000, 43, 0, 0, 0);
    addStep(16'hC801, 45, 0, 0, 0);
    addStep(16'hCA01, 47, 0, 0, 0);
    addStep(16'hF000, 46, 0, 0, 0);
    addStep(16'hC401, 48, 0, 0, 0);
    // Overflowing add
    addStep(16'h0E33, 49, 0, 0, 0);
    addStep(16'hCC01, 51, 0, 0, 0);
    addStep(16'hF000, 50, 0, 0, 0);
    // Unconditional hops with one going backward
    addStep(16'hCE02, 54, 0, 0, 0);
    addStep(16'hCE03, 56, 0, 0, 0);
    addStep(16'hF000, 53, 0, 0, 0);
    addStep(16'hCFFD, 52, 0, 0, 0);
    addStep(16'hF000, 55, 0, 0, 0);
    // JAL out, JR back, link value stored
    addStep(16'hD003, 60, 0, 0, 0);
    addStep(16'h9F18, 58, 1, 16'h0038, 16'h0039);
    addStep(16'hCE02, 61, 0, 0, 0);
    addStep(16'hF000, 59, 0, 0, 0);
    addStep(16'hE0F0, 57, 0, 0, 0);
    // ADDZ with Z clear, then with Z set
    addStep(16'h1423, 62, 0, 0, 0);
    addStep(16'h9419, 63, 1, 16'h0039, 16'hFEFE);
    addStep(16'h2E33, 64, 0, 0, 0);
    addStep(16'h1423, 65, 0, 0, 0);
    addStep(16'h941A, 66, 1, 16'h003A, 16'h9204);
    addStep(16'hF000, 66, 0, 0, 0);
  endtask

  // Bound from program length plus reset and halt margin
  initial begin
    #1;
    #((steps.size() + ResetCycles + MarginCycles) * PeriodNs);
    $display("Timeout: the core did not reach the end of the program in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  initial begin
    int   pcExp;
    logic done;
    stepT cur;
    rstN = 1'b0;
    imemData = '0;
    done = 1'b0;
    loadProgram();
    // HLT everywhere outside the program with its address in the low bits
    for (int i = 0; i < RomDepth; i++) begin
      rom[i] = {4'hF, 12'(i)};
    end
    for (int i = 0; i < steps.size(); i++) begin
      rom[i] = steps[i].instr;
    end
    for (int i = 0; i < RamDepth; i++) begin
      ram[i] = {8'(i) ^ 8'h5A, ~8'(i)};
    end
    ram[8'h50] = 16'hBEEF;
    ram[8'h4E] = 16'h1357;
    repeat (ResetCycles) @(negedge clk);
    rstN = 1'b1;
    pcExp = 0;
    // Sample a little after the falling edge once the instruction has settled
    while (!done) begin
      #1;
      compareValue("imemAddr", imemAddr, pcExp);
      compareValue("halted", halted, 1'b0);
      cur = steps[pcExp];
      compareValue("dmemReq.we", dmemReq.we, cur.store);
      // Only LW reads the data memory
      compareValue("dmemReq.re", dmemReq.re, cur.instr[15:12] == 4'h8);
      if (cur.store) begin
        compareValue("dmemReq.addr", dmemReq.addr, cur.addr);
        compareValue("dmemReq.wdata", dmemReq.wdata, cur.data);
      end
      @(negedge clk);
      pcExp = cur.nextAddr;
      done = (cur.instr[15:12] == 4'hF);
    end
    // PC frozen and no strobes once halted
    // A store and a load take turns at the frozen PC
    for (int i = 0; i < 6; i++) begin
      #1;
      compareValue("halted", halted, 1'b1);
      compareValue("imemAddr", imemAddr, pcExp);
      compareValue("dmemReq.we", dmemReq.we, 1'b0);
      compareValue("dmemReq.re", dmemReq.re, 1'b0);
      rom[pcExp] = (i % 2 == 0) ? 16'h9411 : 16'h8CB0;
      @(negedge clk);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/alu.sv
hdl/fetchUnit.sv
hdl/cpuCore.sv
testbench/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/ctrlPkg.sv
      - hdl/instrDecode.sv
      - hdl/regFile.sv
      - hdl/alu.sv
      - hdl/fetchUnit.sv
      - hdl/cpuCore.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/cpuCoreTb.sv
